// ==== build.f ====
src/fp_fmt_pkg.sv
src/fp_op_pkg.sv
src/fp_decomp.sv
src/fp_compare.sv
src/fp_zl_unit.sv
src/fp_result_reg.sv
src/fp_zl_top.sv
dv/tb_fp_zl.sv

// ==== run.sh ====
#!/bin/sh
# compiles the testbench and the fpu with verilator, then runs it
# the exit status of the simulation is the test result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_fp_zl -f build.f -o tb_fp_zl
./obj_dir/tb_fp_zl

// ==== dv/fp_zl_vectors.txt ====
// op func cr a b result nanx stall, all hex, stall in cycles of out_ready_i low
// one transaction per line, a line with op ff ends the list
1 00 0 c0200000 00000000 40200000 0 0
1 01 0 3f800000 00000000 bf800000 0 0
1 02 0 80000000 00000000 00000000 0 0
1 03 0 7fc00000 00000000 7fc00000 1 0
1 02 0 7f800001 00000000 ff800001 1 1
1 00 0 ff800000 00000000 7f800000 0 0
1 05 0 40400000 00000000 3fc00000 0 0
1 05 0 c0200000 00000000 bfa00000 0 0
1 04 0 00000000 00000000 00000000 0 0
1 04 0 80000010 00000000 bf800000 0 0
1 04 0 40400000 00000000 3f800000 0 0
1 04 1 80000000 00000000 00000000 0 2
1 04 1 c0200000 00000000 00000003 0 0
1 04 1 00000001 00000000 00000001 0 0
1 09 0 ff800000 00000000 80000001 0 0
1 09 0 3f800000 00000000 00000040 0 0
1 09 0 80000010 00000000 80000004 0 0
1 09 0 00000000 00000000 00000010 0 0
1 09 0 7f800001 00000000 00000100 0 0
1 09 0 ffc00000 00000000 80000200 0 3
1 06 0 7fc00000 00000000 00000001 0 0
1 06 0 3f800000 00000000 00000000 0 0
1 07 0 7f800000 00000000 00000000 0 0
1 07 0 80000010 00000000 00000001 0 0
1 08 0 7f800001 00000000 00000001 0 0
2 00 0 3f800000 40000000 00000003 0 0
2 00 0 00000000 80000000 00000000 0 0
2 00 0 40400000 c0200000 00000001 0 1
2 00 0 7fc00000 3f800000 00000001 1 0
3 00 0 c0200000 3f800000 00000001 0 0
3 00 0 ff800000 c0200000 00000001 0 0
4 00 0 40000000 40000000 00000001 0 0
5 00 0 00000000 80000000 00000001 0 0
6 00 0 3f800000 3f800000 00000000 0 0
3 00 0 7fc00000 3f800000 00000000 1 0
4 00 0 3f800000 7f800001 00000000 1 0
5 00 0 ffc00000 ffc00000 00000000 1 0
6 00 0 3f800000 7f800001 00000001 1 2
0 00 0 3f800000 3f800000 00000000 0 0
1 1f 0 3f800000 00000000 00000000 0 0
ff 00 0 00000000 00000000 00000000 0 0

// ==== dv/tb_fp_zl.sv ====
// ========================================
// vectors come from dv/fp_zl_vectors.txt, run from the project root
// pass 0 stalls as the file says, pass 1 stalls at random
// ========================================

`timescale 1ns/1ps

module tb_fp_zl;

  // most transactions the file may hold
  localparam int MAX_VEC = 64;
  // hex words per vector line
  localparam int VEC_WORDS = 8;
  // cycles without any handshake before giving up
  localparam int TIMEOUT_CYC = 100;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  fp_op_pkg::major_op_t  op_i;
  fp_op_pkg::flt1_func_t func_i;
  logic                  cr_form_i;
  fp_fmt_pkg::fp_t       a_i;
  fp_fmt_pkg::fp_t       b_i;
  logic                  out_valid_o;
  logic                  out_ready_i;
  fp_fmt_pkg::fp_t       result_o;
  logic                  nanx_o;

  // raw vector words, VEC_WORDS per transaction
  logic [31:0]     vec_mem [0:VEC_WORDS*MAX_VEC-1];
  int              num_vec;
  // scoreboard, one entry per accepted input, oldest first
  fp_fmt_pkg::fp_t exp_result_q[$];
  logic            exp_nanx_q[$];
  // results seen over both passes
  int              returned;
  // index of the result waiting at the output within a pass
  int              out_idx;

  fp_zl_top i_fp_zl_top (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .op_i        (op_i),
    .func_i      (func_i),
    .cr_form_i   (cr_form_i),
    .a_i         (a_i),
    .b_i         (b_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .nanx_o      (nanx_o)
  );

  // 8 ns period
  always #4 clk_i = ~clk_i;

  // ========================================
  // failure reporting and compares
  // ========================================

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_result(input fp_fmt_pkg::fp_t got, input fp_fmt_pkg::fp_t want);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: result_o got %h expected %h (output %0d)",
               $time, got, want, out_idx);
      abort_run();
    end
  endtask

  task automatic check_nanx(input logic got, input logic want);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: nanx_o got %b expected %b (output %0d)",
               $time, got, want, out_idx);
      abort_run();
    end
  endtask

  // handshake flags
  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, want);
      abort_run();
    end
  endtask

  // ========================================
  // stimulus helpers
  // ========================================

  // cycles that out_ready_i stays low for the next result
  function automatic int pick_stall(input int pass, input int idx);
    if (pass == 0) begin
      return (idx < num_vec) ? int'(vec_mem[VEC_WORDS*idx+7]) : 0;
    end
    // half the results leave at once, the rest wait up to 3 cycles
    return ($urandom % 2 == 0) ? 0 : int'($urandom % 4);
  endfunction

  task automatic apply_vector(input int idx);
    int base;
    base       = VEC_WORDS * idx;
    op_i       = fp_op_pkg::major_op_t'(vec_mem[base][3:0]);
    func_i     = fp_op_pkg::flt1_func_t'(vec_mem[base+1][4:0]);
    cr_form_i  = vec_mem[base+2][0];
    a_i        = vec_mem[base+3];
    b_i        = vec_mem[base+4];
    in_valid_i = 1'b1;
  endtask

  // drives every vector once and drains the scoreboard
  task automatic run_pass(input int pass);
    int              idx;
    int              idle;
    int              stall_left;
    logic            acc;
    logic            ret;
    logic            prev_acc;
    logic            prev_valid;
    logic            prev_ready;
    logic            exp_valid;
    logic            done;
    fp_fmt_pkg::fp_t held_result;
    logic            held_nanx;
    idx         = 0;
    idle        = 0;
    out_idx     = 0;
    acc         = 1'b0;
    prev_acc    = 1'b0;
    prev_valid  = 1'b0;
    prev_ready  = 1'b0;
    exp_valid   = 1'b0;
    done        = 1'b0;
    held_result = '0;
    held_nanx   = 1'b0;
    stall_left  = pick_stall(pass, 0);
    while (!done) begin
      @(posedge clk_i);
      #1;
      // a refused input stays on the bus until it is taken
      if (!in_valid_i || acc) begin
        if (idx < num_vec && (pass == 0 || $urandom % 4 != 0)) begin
          apply_vector(idx);
        end else begin
          in_valid_i = 1'b0;
        end
      end
      out_ready_i = (stall_left == 0);
      // mid cycle, all outputs settled
      @(negedge clk_i);
      // valid one cycle after acceptance, and held while stalled
      exp_valid = prev_acc || (prev_valid && !prev_ready);
      check_flag("out_valid_o", out_valid_o, exp_valid);
      check_flag("in_ready_o", in_ready_o, !exp_valid || out_ready_i);
      if (prev_valid && !prev_ready) begin
        check_result(result_o, held_result);
        check_nanx(nanx_o, held_nanx);
      end
      acc = in_valid_i && (!exp_valid || out_ready_i);
      ret = exp_valid && out_ready_i;
      if (ret) begin
        if (exp_result_q.size() == 0) begin
          $display("a result came out at %0t with no input pending", $time);
          abort_run();
        end
        check_result(result_o, exp_result_q.pop_front());
        check_nanx(nanx_o, exp_nanx_q.pop_front());
        returned++;
        out_idx++;
        stall_left = pick_stall(pass, out_idx);
      end else if (exp_valid && stall_left > 0) begin
        stall_left--;
      end
      // expected values straight from the vector line
      if (acc) begin
        exp_result_q.push_back(vec_mem[VEC_WORDS*idx+5]);
        exp_nanx_q.push_back(vec_mem[VEC_WORDS*idx+6][0]);
        idx++;
      end
      prev_acc    = acc;
      prev_valid  = exp_valid;
      prev_ready  = out_ready_i;
      held_result = result_o;
      held_nanx   = nanx_o;
      idle        = (acc || ret) ? 0 : idle + 1;
      if (idle >= TIMEOUT_CYC) begin
        $display("timeout in pass %0d, no handshake for %0d cycles", pass, TIMEOUT_CYC);
        abort_run();
      end
      done = (idx == num_vec) && (exp_result_q.size() == 0);
    end
  endtask

  // ========================================
  // main sequence
  // ========================================

  initial begin
    void'($urandom(66));
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    op_i        = fp_op_pkg::OP_NONE;
    func_i      = fp_op_pkg::F_ABS;
    cr_form_i   = 1'b0;
    a_i         = '0;
    b_i         = '0;
    out_ready_i = 1'b1;
    returned    = 0;
    out_idx     = 0;
    $readmemh("dv/fp_zl_vectors.txt", vec_mem);
    // count lines up to the end marker
    num_vec = 0;
    while (num_vec < MAX_VEC && vec_mem[VEC_WORDS*num_vec] !== 32'hff) begin
      num_vec++;
    end
    if (num_vec == 0 || num_vec == MAX_VEC) begin
      $display("vector file is missing, empty or has no end marker");
      abort_run();
    end
    // reset over 3 rising edges
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_flag("out_valid_o", out_valid_o, 1'b0);
    check_flag("in_ready_o", in_ready_o, 1'b1);
    run_pass(0);
    run_pass(1);
    if (returned == 2 * num_vec && exp_result_q.size() == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("only %0d of %0d results came back", returned, 2 * num_vec);
      abort_run();
    end
  end

endmodule

// ==== src/fp_zl_top.sv ====
// ========================================
// zero latency unit behind one result register
// result appears one cycle after the input handshake
// ========================================

`timescale 1ns/1ps

module fp_zl_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  fp_op_pkg::major_op_t  op_i,
  input  fp_op_pkg::flt1_func_t func_i,
  input  logic                  cr_form_i,
  input  fp_fmt_pkg::fp_t       a_i,
  input  fp_fmt_pkg::fp_t       b_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output fp_fmt_pkg::fp_t       result_o,
  output logic                  nanx_o
);

  // combinational result into the register
  fp_fmt_pkg::fp_t unit_result;
  logic            unit_nanx;

  fp_zl_unit i_fp_zl_unit (
    .op_i      (op_i),
    .func_i    (func_i),
    .cr_form_i (cr_form_i),
    .a_i       (a_i),
    .b_i       (b_i),
    .result_o  (unit_result),
    .nanx_o    (unit_nanx)
  );

  fp_result_reg i_fp_result_reg (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .result_i    (unit_result),
    .nanx_i      (unit_nanx),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .nanx_o      (nanx_o)
  );

endmodule

// ==== src/fp_result_reg.sv ====
// ========================================
// single entry output register, valid/ready on both sides
// one result in flight, full throughput when out_ready_i is high
// ========================================

`timescale 1ns/1ps

module fp_result_reg (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  fp_fmt_pkg::fp_t result_i,
  input  logic            nanx_i,
  output logic            out_valid_o,
  input  logic            out_ready_i,
  output fp_fmt_pkg::fp_t result_o,
  output logic            nanx_o
);

  // entry occupied
  logic            valid_q;
  // held payload
  fp_fmt_pkg::fp_t result_q;
  logic            nanx_q;
  // input handshake this cycle
  logic            accept;

  // free slot, or the held result leaves this edge
  assign in_ready_o = !valid_q || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // payload only moves on a handshake
  always_ff @(posedge clk_i) begin
    if (accept) begin
      result_q <= result_i;
      nanx_q   <= nanx_i;
    end
  end

  assign out_valid_o = valid_q;
  assign result_o    = result_q;
  assign nanx_o      = nanx_q;

  // ========================================
  // assertions
  // ========================================

  // stalled output holds valid and payload
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o) && $stable(nanx_o));

  // nothing comes out the cycle after reset
  assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_o);

  // payload changes only after an input that was offered and taken
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$stable(result_o) || !$stable(nanx_o) |-> $past(in_valid_i && in_ready_o));

endmodule

// ==== src/fp_zl_unit.sv ====
// ========================================
// zero latency ops, fully combinational
// b must be zero for single operand ops
// else a nan in b shows up on nanx
// ========================================

`timescale 1ns/1ps

module fp_zl_unit (
  input  fp_op_pkg::major_op_t  op_i,
  input  fp_op_pkg::flt1_func_t func_i,
  input  logic                  cr_form_i,
  input  fp_fmt_pkg::fp_t       a_i,
  input  fp_fmt_pkg::fp_t       b_i,
  output fp_fmt_pkg::fp_t       result_o,
  output logic                  nanx_o
);

  // fields and flags of a
  logic                              a_sign;
  fp_fmt_pkg::fp_exp_t               a_exp;
  fp_fmt_pkg::fp_man_t               a_man;
  logic                              a_zero;
  logic                              a_subnorm;
  logic                              a_inf;
  logic                              a_qnan;
  logic                              a_snan;
  logic                              a_nan;
  // a against b
  logic                              cmp_eq;
  logic                              cmp_lt;
  logic                              cmp_le;
  logic                              cmp_unord;
  // normal means none of the special encodings
  logic                              a_normal;
  // fclass category bits
  logic [fp_fmt_pkg::CLASS_W-1:0]    a_class;

  fp_decomp i_fp_decomp (
    .a_i       (a_i),
    .sign_o    (a_sign),
    .exp_o     (a_exp),
    .man_o     (a_man),
    .zero_o    (a_zero),
    .subnorm_o (a_subnorm),
    .inf_o     (a_inf),
    .qnan_o    (a_qnan),
    .snan_o    (a_snan),
    .nan_o     (a_nan)
  );

  fp_compare i_fp_compare (
    .a_i     (a_i),
    .b_i     (b_i),
    .eq_o    (cmp_eq),
    .lt_o    (cmp_lt),
    .le_o    (cmp_le),
    .unord_o (cmp_unord)
  );

  assign a_normal = !(a_zero || a_subnorm || a_inf || a_nan);

  // ========================================
  // fclass one hot, nans only set their own bit
  // ========================================
  assign a_class = {a_qnan,
                    a_snan,
                    !a_sign && a_inf,
                    !a_sign && a_normal,
                    !a_sign && a_subnorm,
                    !a_sign && a_zero,
                    a_sign && a_zero,
                    a_sign && a_subnorm,
                    a_sign && a_normal,
                    a_sign && a_inf};

  // ========================================
  // op decode and result mux
  // ========================================
  always_comb begin
    result_o = '0;
    nanx_o   = 1'b0;
    case (op_i)
      fp_op_pkg::OP_FLT1: begin
        case (func_i)
          fp_op_pkg::F_ABS: begin
            result_o = {1'b0, a_exp, a_man};
            nanx_o   = cmp_unord;
          end
          fp_op_pkg::F_NABS: begin
            result_o = {1'b1, a_exp, a_man};
            nanx_o   = cmp_unord;
          end
          fp_op_pkg::F_NEG: begin
            result_o = {!a_sign, a_exp, a_man};
            nanx_o   = cmp_unord;
          end
          fp_op_pkg::F_MOV: begin
            result_o = a_i;
            nanx_o   = cmp_unord;
          end
          fp_op_pkg::F_SIGN: begin
            // cr form: 00 zero, 11 negative, 01 positive
            if (cr_form_i) begin
              result_o = a_zero ? '0 : fp_fmt_pkg::fp_t'({a_sign, 1'b1});
            end else if (a_zero) begin
              result_o = '0;
            end else begin
              result_o = a_sign ? fp_fmt_pkg::FP_NEG_ONE : fp_fmt_pkg::FP_POS_ONE;
            end
          end
          // keep sign and fraction, value lands in [1,2)
          fp_op_pkg::F_MAN:    result_o = {a_sign, fp_fmt_pkg::EXP_BIAS, a_man};
          fp_op_pkg::F_ISNAN:  result_o = fp_fmt_pkg::fp_t'(a_nan);
          // max exponent is inf or nan
          fp_op_pkg::F_FINITE: result_o = fp_fmt_pkg::fp_t'(a_exp != '1);
          fp_op_pkg::F_UNORD:  result_o = fp_fmt_pkg::fp_t'(cmp_unord);
          fp_op_pkg::F_CLASS: begin
            result_o = fp_fmt_pkg::fp_t'(a_class);
            result_o[fp_fmt_pkg::FP_W-1] = a_sign;
          end
          default: result_o = '0;
        endcase
      end
      fp_op_pkg::OP_FCMP: begin
        // 00 equal, 11 less, 01 greater or unordered
        if (cmp_eq) begin
          result_o = '0;
        end else if (cmp_lt) begin
          result_o = fp_fmt_pkg::fp_t'(2'b11);
        end else begin
          result_o = fp_fmt_pkg::fp_t'(2'b01);
        end
        nanx_o = cmp_unord;
      end
      fp_op_pkg::OP_FSLT: begin
        result_o = fp_fmt_pkg::fp_t'(cmp_lt);
        nanx_o   = cmp_unord;
      end
      fp_op_pkg::OP_FSLE: begin
        result_o = fp_fmt_pkg::fp_t'(cmp_le);
        nanx_o   = cmp_unord;
      end
      fp_op_pkg::OP_FSEQ: begin
        result_o = fp_fmt_pkg::fp_t'(cmp_eq);
        nanx_o   = cmp_unord;
      end
      fp_op_pkg::OP_FSNE: begin
        // unordered counts as not equal
        result_o = fp_fmt_pkg::fp_t'(!cmp_eq);
        nanx_o   = cmp_unord;
      end
      default: result_o = '0;
    endcase
  end

endmodule

// ==== src/fp_compare.sv ====
// ========================================
// ieee ordered compare, a against b
// +0 equals -0, any nan gives unordered
// ========================================

`timescale 1ns/1ps

module fp_compare (
  input  fp_fmt_pkg::fp_t a_i,
  input  fp_fmt_pkg::fp_t b_i,
  output logic            eq_o,
  output logic            lt_o,
  output logic            le_o,
  output logic            unord_o
);

  // sign and magnitude of each side
  logic                        sign_a;
  logic                        sign_b;
  logic [fp_fmt_pkg::FP_W-2:0] mag_a;
  logic [fp_fmt_pkg::FP_W-2:0] mag_b;
  // nan on either side
  logic                        nan_a;
  logic                        nan_b;
  // both are zero whatever the signs
  logic                        both_zero;
  // relations before the nan mask
  logic                        eq_raw;
  logic                        lt_raw;

  assign sign_a = a_i[fp_fmt_pkg::FP_W-1];
  assign sign_b = b_i[fp_fmt_pkg::FP_W-1];
  assign mag_a  = a_i[fp_fmt_pkg::FP_W-2:0];
  assign mag_b  = b_i[fp_fmt_pkg::FP_W-2:0];

  // exponent all ones with a nonzero fraction
  assign nan_a = (&mag_a[fp_fmt_pkg::FP_W-2:fp_fmt_pkg::MAN_W]) &&
                 (|mag_a[fp_fmt_pkg::MAN_W-1:0]);
  assign nan_b = (&mag_b[fp_fmt_pkg::FP_W-2:fp_fmt_pkg::MAN_W]) &&
                 (|mag_b[fp_fmt_pkg::MAN_W-1:0]);

  assign both_zero = (mag_a == '0) && (mag_b == '0);
  assign eq_raw    = (a_i == b_i) || both_zero;

  // sign magnitude order
  always_comb begin
    unique case ({sign_a, sign_b})
      // both positive, larger magnitude is larger
      2'b00: lt_raw = (mag_a < mag_b);
      // both negative, order flips
      2'b11: lt_raw = (mag_a > mag_b);
      // a negative, b positive, unless -0 vs +0
      2'b10: lt_raw = !both_zero;
      default: lt_raw = 1'b0;
    endcase
  end

  // ========================================
  // nan masking
  // ========================================

  assign unord_o = nan_a || nan_b;
  assign eq_o    = eq_raw && !unord_o;
  assign lt_o    = lt_raw && !unord_o;
  assign le_o    = (eq_raw || lt_raw) && !unord_o;

endmodule

// ==== src/fp_decomp.sv ====
// ========================================
// pure combinational field split
// flags assume ieee single precision encoding
// ========================================

`timescale 1ns/1ps

module fp_decomp (
  input  fp_fmt_pkg::fp_t     a_i,
  output logic                sign_o,
  output fp_fmt_pkg::fp_exp_t exp_o,
  output fp_fmt_pkg::fp_man_t man_o,
  output logic                zero_o,
  output logic                subnorm_o,
  output logic                inf_o,
  output logic                qnan_o,
  output logic                snan_o,
  output logic                nan_o
);

  // exponent all zeros or all ones
  logic exp_zero;
  logic exp_ones;
  // fraction is zero
  logic man_zero;

  // ========================================
  // raw fields
  // ========================================

  assign sign_o = a_i[fp_fmt_pkg::FP_W-1];
  assign exp_o  = a_i[fp_fmt_pkg::FP_W-2:fp_fmt_pkg::MAN_W];
  assign man_o  = a_i[fp_fmt_pkg::MAN_W-1:0];

  assign exp_zero = (exp_o == '0);
  assign exp_ones = &exp_o;
  assign man_zero = (man_o == '0);

  // ========================================
  // classification
  // ========================================

  // +0 and -0 both count as zero
  assign zero_o    = exp_zero && man_zero;
  // denormal, no hidden bit
  assign subnorm_o = exp_zero && !man_zero;
  // max exponent splits into inf and nan on the fraction
  assign inf_o     = exp_ones && man_zero;
  assign nan_o     = exp_ones && !man_zero;
  // top fraction bit set means quiet
  assign qnan_o    = nan_o && man_o[fp_fmt_pkg::MAN_W-1];
  assign snan_o    = nan_o && !man_o[fp_fmt_pkg::MAN_W-1];

endmodule

// ==== src/fp_op_pkg.sv ====
// ========================================
// op and func codes of the zero latency unit
// codes not listed here give a zero result
// ========================================

package fp_op_pkg;

  // ========================================
  // major opcode
  // ========================================

  // flt1 selects a func code, the rest are two operand ops
  typedef enum logic [3:0] {
    OP_NONE = 4'h0,
    OP_FLT1 = 4'h1,
    OP_FCMP = 4'h2,
    OP_FSLT = 4'h3,
    OP_FSLE = 4'h4,
    OP_FSEQ = 4'h5,
    OP_FSNE = 4'h6
  } major_op_t;

  // ========================================
  // func code under OP_FLT1
  // ========================================

  typedef enum logic [4:0] {
    F_ABS    = 5'h00,
    F_NABS   = 5'h01,
    F_NEG    = 5'h02,
    F_MOV    = 5'h03,
    F_SIGN   = 5'h04,
    F_MAN    = 5'h05,
    F_ISNAN  = 5'h06,
    F_FINITE = 5'h07,
    F_UNORD  = 5'h08,
    F_CLASS  = 5'h09
  } flt1_func_t;

endpackage

// ==== src/fp_fmt_pkg.sv ====
// ========================================
// ieee 754 single precision format only
// widths are fixed here, modules take no width parameter
// ========================================

package fp_fmt_pkg;

  // ========================================
  // field widths
  // ========================================

  // full operand width
  localparam int FP_W = 32;
  // biased exponent field
  localparam int EXP_W = 8;
  // fraction field, hidden bit not stored
  localparam int MAN_W = 23;

  // number of fclass category bits
  localparam int CLASS_W = 10;

  // ========================================
  // typedefs
  // ========================================

  // operand or result word
  typedef logic [FP_W-1:0] fp_t;
  // exponent field as stored
  typedef logic [EXP_W-1:0] fp_exp_t;
  // fraction field as stored
  typedef logic [MAN_W-1:0] fp_man_t;

  // ========================================
  // constants
  // ========================================

  // exponent bias, fman writes this so the value lands in [1,2)
  localparam fp_exp_t EXP_BIAS = 8'd127;

  // fsign results in the float form
  // +1.0 is 0x3f800000
  localparam fp_t FP_POS_ONE = {1'b0, EXP_BIAS, {MAN_W{1'b0}}};
  // -1.0 is 0xbf800000
  localparam fp_t FP_NEG_ONE = {1'b1, EXP_BIAS, {MAN_W{1'b0}}};

endpackage
